// ==== verilog/cache_pkg.sv ====
package cache_pkg;

  // cacheable DRAM window
  localparam logic [31:0] DRAM_BASE = 32'h8000_0000;
  localparam logic [31:0] DRAM_SIZE = 32'h0001_0000;

  // default cache geometry
  localparam int LINE_BYTES  = 4;
  localparam int CACHE_BYTES = 1024;

  // cpu load/store request, held until the response
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  strb;
    logic        ren;
    logic        wen;
  } cpu_req_t;

  typedef enum logic {
    BUS_READ,
    BUS_WRITE
  } bus_op_e;

  // one single-beat transfer for the AXI master
  typedef struct packed {
    bus_op_e     op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
  } bus_cmd_t;

  // line update into the store
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
    logic        dirty;
    logic        en;
  } line_wr_t;

  typedef enum logic [2:0] {
    HIT_CMP,
    SEND_ADDR,
    WAIT_DATA,
    END_ACCESS,
    SEND_DATA,
    WAIT_WRITING
  } cache_state_e;

endpackage

// ==== verilog/direct_map.sv ====
`timescale 1ns/1ps

module direct_map #(
  parameter int LINE_BYTES  = cache_pkg::LINE_BYTES,
  parameter int CACHE_BYTES = cache_pkg::CACHE_BYTES
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [31:0]          lookup_addr,
  input  cache_pkg::line_wr_t  line_wr,
  output logic                 hit,
  output logic                 dirty,
  output logic [31:0]          line_data,
  output logic [31:0]          victim_addr
);

  localparam int LINES    = CACHE_BYTES / LINE_BYTES;
  localparam int OFFSET_W = $clog2(LINE_BYTES);
  localparam int INDEX_W  = $clog2(LINES);
  localparam int TAG_W    = 32 - OFFSET_W - INDEX_W;

  logic [TAG_W-1:0] tag_mem [LINES];
  logic [31:0]      data_mem [LINES];
  logic [LINES-1:0] valid_bits;
  logic [LINES-1:0] dirty_bits;

  logic [INDEX_W-1:0] rd_index;
  logic [INDEX_W-1:0] wr_index;
  logic [TAG_W-1:0]   rd_tag;
  logic [TAG_W-1:0]   stored_tag;

  // index sits right above the line offset
  assign rd_index   = lookup_addr[OFFSET_W +: INDEX_W];
  assign rd_tag     = lookup_addr[31 -: TAG_W];
  assign wr_index   = line_wr.addr[OFFSET_W +: INDEX_W];
  assign stored_tag = tag_mem[rd_index];

  assign hit       = valid_bits[rd_index] && (stored_tag == rd_tag);
  // an invalid entry never reports dirty
  assign dirty     = valid_bits[rd_index] && dirty_bits[rd_index];
  assign line_data = data_mem[rd_index];

  // address of whatever line currently occupies this index
  assign victim_addr = {stored_tag, rd_index, {OFFSET_W{1'b0}}};

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
    end else if (line_wr.en) begin
      valid_bits[wr_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (line_wr.en) begin
      tag_mem[wr_index]    <= line_wr.addr[31 -: TAG_W];
      data_mem[wr_index]   <= line_wr.data;
      dirty_bits[wr_index] <= line_wr.dirty;
    end
  end

endmodule

// ==== verilog/axi_lite_master.sv ====
`timescale 1ns/1ps

module axi_lite_master (
  input  logic                 clk,
  input  logic                 reset,

  // command side
  input  cache_pkg::bus_cmd_t  bus_cmd,
  input  logic                 cmd_valid,
  output logic                 cmd_ready,
  output logic                 rsp_valid,
  output logic [31:0]          rsp_data,

  // read channels
  input  logic                 arready,
  input  logic                 rvalid,
  input  logic [31:0]          rdata,
  output logic                 arvalid,
  output logic [31:0]          araddr,
  output logic                 rready,

  // write channels
  input  logic                 awready,
  input  logic                 wready,
  input  logic                 bvalid,
  output logic [31:0]          awaddr,
  output logic                 awvalid,
  output logic [31:0]          wdata,
  output logic [3:0]           wstrb,
  output logic                 wvalid,
  output logic                 bready
);

  typedef enum logic [1:0] {
    M_IDLE,
    M_READ,
    M_WRITE
  } master_state_e;

  master_state_e m_state;

  assign cmd_ready = (m_state == M_IDLE);

  always_ff @(posedge clk) begin
    if (reset) begin
      m_state   <= M_IDLE;
      arvalid   <= 1'b0;
      rready    <= 1'b0;
      awvalid   <= 1'b0;
      wvalid    <= 1'b0;
      bready    <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= 1'b0;
      case (m_state)
        M_IDLE: begin
          if (cmd_valid) begin
            if (bus_cmd.op == cache_pkg::BUS_READ) begin
              arvalid <= 1'b1;
              m_state <= M_READ;
            end else begin
              awvalid <= 1'b1;
              wvalid  <= 1'b1;
              bready  <= 1'b1;
              m_state <= M_WRITE;
            end
          end
        end
        M_READ: begin
          if (arvalid && arready) begin
            arvalid <= 1'b0;
            rready  <= 1'b1;
          end
          if (rready && rvalid) begin
            rready    <= 1'b0;
            rsp_valid <= 1'b1;
            m_state   <= M_IDLE;
          end
        end
        M_WRITE: begin
          // aw and w beats retire independently
          if (awready) begin
            awvalid <= 1'b0;
          end
          if (wready) begin
            wvalid <= 1'b0;
          end
          if (bvalid) begin
            bready    <= 1'b0;
            rsp_valid <= 1'b1;
            m_state   <= M_IDLE;
          end
        end
        default: begin
          m_state <= M_IDLE;
        end
      endcase
    end
  end

  // payload, latched once per command
  always_ff @(posedge clk) begin
    if (m_state == M_IDLE && cmd_valid) begin
      araddr <= bus_cmd.addr;
      awaddr <= bus_cmd.addr;
      wdata  <= bus_cmd.data;
      wstrb  <= bus_cmd.strb;
    end
    if (m_state == M_READ && rready && rvalid) begin
      rsp_data <= rdata;
    end
  end

endmodule

// ==== verilog/d_cache.sv ====
`timescale 1ns/1ps

module d_cache #(
  parameter int LINE_BYTES  = cache_pkg::LINE_BYTES,
  parameter int CACHE_BYTES = cache_pkg::CACHE_BYTES
) (
  input  logic                 clk,
  input  logic                 reset,

  // cpu side
  input  cache_pkg::cpu_req_t  cpu_req,
  output logic [31:0]          read_data,
  output logic                 read_valid,
  output logic                 write_ready,

  // store side
  output logic [31:0]          lookup_addr,
  output cache_pkg::line_wr_t  line_wr,
  input  logic                 hit,
  input  logic                 dirty,
  input  logic [31:0]          line_data,
  input  logic [31:0]          victim_addr,

  // bus master side
  output cache_pkg::bus_cmd_t  bus_cmd,
  output logic                 cmd_valid,
  input  logic                 cmd_ready,
  input  logic                 rsp_valid,
  input  logic [31:0]          rsp_data
);

  localparam int OFFSET_W = $clog2(LINE_BYTES);

  cache_pkg::cache_state_e state;

  logic        cacheable;
  logic        active;
  logic        full_store;
  logic        direct_write;
  logic [4:0]  lane_shift;
  logic [31:0] lane_mask;
  logic [31:0] word_addr;
  logic [31:0] fill_word;
  logic [31:0] cur_word;
  logic [31:0] merged;

  // bring the addressed lanes down to bit 0, keep the rest raw
  function automatic logic [31:0] align_read(
    input logic [31:0] word,
    input logic [31:0] mask,
    input logic [4:0]  shift
  );
    logic [31:0] low_mask;
    low_mask = mask >> shift;
    return ((word >> shift) & low_mask) | (word & ~low_mask);
  endfunction

  // single unsigned compare, wraps below the base
  assign cacheable = (cpu_req.addr - cache_pkg::DRAM_BASE) < cache_pkg::DRAM_SIZE;

  // ignore the request while its response pulse is out
  assign active = (cpu_req.ren || cpu_req.wen) && !read_valid && !write_ready;

  assign lane_shift = {cpu_req.addr[1:0], 3'b000};
  assign lane_mask  = {{8{cpu_req.strb[3]}}, {8{cpu_req.strb[2]}},
                       {8{cpu_req.strb[1]}}, {8{cpu_req.strb[0]}}};

  assign full_store = cpu_req.wen && (cpu_req.strb == 4'b1111) && (cpu_req.addr[1:0] == 2'b00);

  // store hit, or whole word over a clean line
  assign direct_write = cacheable && cpu_req.wen && (hit || (!dirty && full_store));

  assign lookup_addr = {cpu_req.addr[31:OFFSET_W], {OFFSET_W{1'b0}}};
  assign word_addr   = {cpu_req.addr[31:2], 2'b00};

  assign cur_word = (state == cache_pkg::END_ACCESS) ? fill_word : line_data;
  assign merged   = (cur_word & ~lane_mask) | ((cpu_req.wdata << lane_shift) & lane_mask);

  always_comb begin
    line_wr.addr  = lookup_addr;
    line_wr.data  = merged;
    line_wr.dirty = cpu_req.wen;
    line_wr.en    = 1'b0;
    case (state)
      cache_pkg::HIT_CMP: begin
        line_wr.en = active && direct_write;
      end
      cache_pkg::END_ACCESS: begin
        // fills go in clean, store fills merged and dirty
        line_wr.en = cacheable;
        if (!cpu_req.wen) begin
          line_wr.data = fill_word;
        end
      end
      cache_pkg::WAIT_WRITING: begin
        line_wr.en = rsp_valid && cacheable && full_store;
      end
      default: begin
        line_wr.en = 1'b0;
      end
    endcase
  end

  always_comb begin
    bus_cmd.op   = cache_pkg::BUS_READ;
    bus_cmd.addr = word_addr;
    bus_cmd.data = cpu_req.wdata << lane_shift;
    bus_cmd.strb = cpu_req.strb;
    cmd_valid    = 1'b0;
    case (state)
      cache_pkg::SEND_ADDR: begin
        cmd_valid = 1'b1;
      end
      cache_pkg::SEND_DATA: begin
        cmd_valid  = 1'b1;
        bus_cmd.op = cache_pkg::BUS_WRITE;
        if (cacheable) begin
          // write-back of the dirty victim
          bus_cmd.addr = victim_addr;
          bus_cmd.data = line_data;
          bus_cmd.strb = 4'b1111;
        end
      end
      default: begin
        cmd_valid = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= cache_pkg::HIT_CMP;
      read_valid  <= 1'b0;
      write_ready <= 1'b0;
    end else begin
      read_valid  <= 1'b0;
      write_ready <= 1'b0;
      case (state)
        cache_pkg::HIT_CMP: begin
          if (active) begin
            if (!cacheable) begin
              state <= cpu_req.wen ? cache_pkg::SEND_DATA : cache_pkg::SEND_ADDR;
            end else if (hit && !cpu_req.wen) begin
              read_valid <= 1'b1;
            end else if (direct_write) begin
              write_ready <= 1'b1;
            end else if (dirty) begin
              state <= cache_pkg::SEND_DATA;
            end else begin
              state <= cache_pkg::SEND_ADDR;
            end
          end
        end
        cache_pkg::SEND_ADDR: begin
          if (cmd_ready) begin
            state <= cache_pkg::WAIT_DATA;
          end
        end
        cache_pkg::WAIT_DATA: begin
          if (rsp_valid) begin
            state <= cache_pkg::END_ACCESS;
          end
        end
        cache_pkg::END_ACCESS: begin
          state <= cache_pkg::HIT_CMP;
          if (cpu_req.wen) begin
            write_ready <= 1'b1;
          end else begin
            read_valid <= 1'b1;
          end
        end
        cache_pkg::SEND_DATA: begin
          if (cmd_ready) begin
            state <= cache_pkg::WAIT_WRITING;
          end
        end
        cache_pkg::WAIT_WRITING: begin
          if (rsp_valid) begin
            // full word lands directly, otherwise fetch the new line
            if (!cacheable || full_store) begin
              write_ready <= 1'b1;
              state       <= cache_pkg::HIT_CMP;
            end else begin
              state <= cache_pkg::SEND_ADDR;
            end
          end
        end
        default: begin
          state <= cache_pkg::HIT_CMP;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == cache_pkg::WAIT_DATA && rsp_valid) begin
      fill_word <= rsp_data;
    end
    if ((state == cache_pkg::HIT_CMP && active) || state == cache_pkg::END_ACCESS) begin
      read_data <= align_read(cur_word, lane_mask, lane_shift);
    end
  end

endmodule

// ==== verilog/data_memory_subsystem.sv ====
`timescale 1ns/1ps

module data_memory_subsystem #(
  parameter int LINE_BYTES  = cache_pkg::LINE_BYTES,
  parameter int CACHE_BYTES = cache_pkg::CACHE_BYTES
) (
  input  logic                 clk,
  input  logic                 reset,

  // cpu side
  input  cache_pkg::cpu_req_t  cpu_req,
  output logic [31:0]          read_data,
  output logic                 read_valid,
  output logic                 write_ready,

  // axi4-lite read
  input  logic                 arready,
  input  logic                 rvalid,
  input  logic [31:0]          rdata,
  output logic                 arvalid,
  output logic [31:0]          araddr,
  output logic                 rready,

  // axi4-lite write
  input  logic                 awready,
  input  logic                 wready,
  input  logic                 bvalid,
  output logic [31:0]          awaddr,
  output logic                 awvalid,
  output logic [31:0]          wdata,
  output logic [3:0]           wstrb,
  output logic                 wvalid,
  output logic                 bready
);

  logic [31:0]         lookup_addr;
  logic [31:0]         line_data;
  logic [31:0]         victim_addr;
  logic                hit;
  logic                dirty;
  cache_pkg::line_wr_t line_wr;

  cache_pkg::bus_cmd_t bus_cmd;
  logic                cmd_valid;
  logic                cmd_ready;
  logic                rsp_valid;
  logic [31:0]         rsp_data;

  d_cache #(
    .LINE_BYTES  (LINE_BYTES),
    .CACHE_BYTES (CACHE_BYTES)
  ) u_d_cache (
    .clk         (clk),
    .reset       (reset),
    .cpu_req     (cpu_req),
    .read_data   (read_data),
    .read_valid  (read_valid),
    .write_ready (write_ready),
    .lookup_addr (lookup_addr),
    .line_wr     (line_wr),
    .hit         (hit),
    .dirty       (dirty),
    .line_data   (line_data),
    .victim_addr (victim_addr),
    .bus_cmd     (bus_cmd),
    .cmd_valid   (cmd_valid),
    .cmd_ready   (cmd_ready),
    .rsp_valid   (rsp_valid),
    .rsp_data    (rsp_data)
  );

  direct_map #(
    .LINE_BYTES  (LINE_BYTES),
    .CACHE_BYTES (CACHE_BYTES)
  ) u_direct_map (
    .clk         (clk),
    .reset       (reset),
    .lookup_addr (lookup_addr),
    .line_wr     (line_wr),
    .hit         (hit),
    .dirty       (dirty),
    .line_data   (line_data),
    .victim_addr (victim_addr)
  );

  axi_lite_master u_axi_lite_master (
    .clk       (clk),
    .reset     (reset),
    .bus_cmd   (bus_cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .rsp_valid (rsp_valid),
    .rsp_data  (rsp_data),
    .arready   (arready),
    .rvalid    (rvalid),
    .rdata     (rdata),
    .arvalid   (arvalid),
    .araddr    (araddr),
    .rready    (rready),
    .awready   (awready),
    .wready    (wready),
    .bvalid    (bvalid),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .bready    (bready)
  );

endmodule

// ==== bench/axi_lite_mem_model.sv ====
`timescale 1ns/1ps

module axi_lite_mem_model (
  input  logic        clk,

  // read channels
  input  logic        arvalid,
  input  logic [31:0] araddr,
  input  logic        rready,
  output logic        arready,
  output logic        rvalid,
  output logic [31:0] rdata,

  // write channels
  input  logic        awvalid,
  input  logic [31:0] awaddr,
  input  logic        wvalid,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        bready,
  output logic        awready,
  output logic        wready,
  output logic        bvalid
);

  // written words, the latest entry for an address wins
  logic [31:0] written_addr [$];
  logic [31:0] written_data [$];

  integer seed = 32'hff30;

  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    logic [31:0] word;
    // unwritten words follow the content rule
    word = addr ^ 32'h5a5a_0000;
    foreach (written_addr[i]) begin
      if (written_addr[i] == addr) begin
        word = written_data[i];
      end
    end
    return word;
  endfunction

  function automatic int random_delay();
    return $unsigned($random(seed)) % 4;
  endfunction

  initial begin
    int          delay;
    logic [31:0] addr;
    arready = 1'b0;
    rvalid  = 1'b0;
    rdata   = '0;
    forever begin
      @(negedge clk);
      if (arvalid) begin
        addr  = {araddr[31:2], 2'b00};
        delay = random_delay();
        repeat (delay) @(negedge clk);
        arready = 1'b1;
        @(negedge clk);
        arready = 1'b0;
        delay   = random_delay();
        repeat (delay) @(negedge clk);
        rvalid = 1'b1;
        rdata  = fetch_word(addr);
        @(posedge clk);
        while (!rready) @(posedge clk);
        @(negedge clk);
        rvalid = 1'b0;
      end
    end
  end

  initial begin
    int          aw_delay;
    int          w_delay;
    int          delay;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] word;
    logic [3:0]  strb;
    awready = 1'b0;
    wready  = 1'b0;
    bvalid  = 1'b0;
    forever begin
      @(negedge clk);
      if (awvalid && wvalid) begin
        addr     = {awaddr[31:2], 2'b00};
        data     = wdata;
        strb     = wstrb;
        aw_delay = random_delay();
        w_delay  = random_delay();
        // aw and w accepted in separate cycles when the delays differ
        for (int i = 0; i < 4; i++) begin
          awready = (i == aw_delay);
          wready  = (i == w_delay);
          @(negedge clk);
        end
        awready = 1'b0;
        wready  = 1'b0;
        word    = fetch_word(addr);
        for (int b = 0; b < 4; b++) begin
          if (strb[b]) begin
            word[8*b +: 8] = data[8*b +: 8];
          end
        end
        written_addr.push_back(addr);
        written_data.push_back(word);
        delay = random_delay();
        repeat (delay) @(negedge clk);
        bvalid = 1'b1;
        @(posedge clk);
        while (!bready) @(posedge clk);
        @(negedge clk);
        bvalid = 1'b0;
      end
    end
  end

endmodule

// ==== bench/tb_data_memory.sv ====
`timescale 1ns/1ps

module tb_data_memory;

  localparam int CLK_PERIOD      = 8;
  localparam int RESET_CYCLES    = 16;
  localparam int CYCLES_PER_TEST = 200;

  // one line of the tests file
  typedef struct packed {
    logic        is_write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  strb;
    logic [31:0] rdata;
    logic [7:0]  n_read;
    logic [7:0]  n_write;
  } test_vec_t;

  logic                clk;
  logic                reset;
  cache_pkg::cpu_req_t cpu_req;
  logic [31:0]         read_data;
  logic                read_valid;
  logic                write_ready;

  logic        arready;
  logic        rvalid;
  logic [31:0] rdata;
  logic        arvalid;
  logic [31:0] araddr;
  logic        rready;
  logic        awready;
  logic        wready;
  logic        bvalid;
  logic [31:0] awaddr;
  logic        awvalid;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        bready;

  test_vec_t tests [$];
  bit        tests_loaded = 1'b0;
  int        ar_total = 0;
  int        aw_total = 0;
  int        pass_count = 0;
  int        fail_count = 0;

  data_memory_subsystem #(
    .LINE_BYTES  (cache_pkg::LINE_BYTES),
    .CACHE_BYTES (cache_pkg::CACHE_BYTES)
  ) u_data_memory_subsystem (
    .clk         (clk),
    .reset       (reset),
    .cpu_req     (cpu_req),
    .read_data   (read_data),
    .read_valid  (read_valid),
    .write_ready (write_ready),
    .arready     (arready),
    .rvalid      (rvalid),
    .rdata       (rdata),
    .arvalid     (arvalid),
    .araddr      (araddr),
    .rready      (rready),
    .awready     (awready),
    .wready      (wready),
    .bvalid      (bvalid),
    .awaddr      (awaddr),
    .awvalid     (awvalid),
    .wdata       (wdata),
    .wstrb       (wstrb),
    .wvalid      (wvalid),
    .bready      (bready)
  );

  axi_lite_mem_model u_mem_model (
    .clk     (clk),
    .arvalid (arvalid),
    .araddr  (araddr),
    .rready  (rready),
    .arready (arready),
    .rvalid  (rvalid),
    .rdata   (rdata),
    .awvalid (awvalid),
    .awaddr  (awaddr),
    .wvalid  (wvalid),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .bready  (bready),
    .awready (awready),
    .wready  (wready),
    .bvalid  (bvalid)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // handshakes seen at the DUT ports
  always @(posedge clk) begin
    if (arvalid && arready) begin
      ar_total <= ar_total + 1;
    end
    if (awvalid && awready) begin
      aw_total <= aw_total + 1;
    end
  end

  task automatic load_tests();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f_op;
    logic [31:0] f_addr;
    logic [31:0] f_wdata;
    logic [31:0] f_strb;
    logic [31:0] f_rdata;
    logic [31:0] f_nr;
    logic [31:0] f_nw;
    test_vec_t   t;
    fd = $fopen("bench/dcache_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open bench/dcache_tests.txt");
    end else begin
      // comment lines do not scan as seven fields
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%h %h %h %h %h %h %h",
                    f_op, f_addr, f_wdata, f_strb, f_rdata, f_nr, f_nw);
        if (n == 7) begin
          t.is_write = f_op[0];
          t.addr     = f_addr;
          t.wdata    = f_wdata;
          t.strb     = f_strb[3:0];
          t.rdata    = f_rdata;
          t.n_read   = f_nr[7:0];
          t.n_write  = f_nw[7:0];
          tests.push_back(t);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_test(input int num, input test_vec_t t);
    int ar_start;
    int aw_start;
    int ar_seen;
    int aw_seen;
    int cycles;
    bit ok;
    ok       = 1'b1;
    ar_start = ar_total;
    aw_start = aw_total;
    @(negedge clk);
    cpu_req.addr  = t.addr;
    cpu_req.wdata = t.wdata;
    cpu_req.strb  = t.strb;
    cpu_req.ren   = !t.is_write;
    cpu_req.wen   = t.is_write;
    @(negedge clk);
    cycles = 1;
    while (!read_valid && !write_ready) begin
      @(negedge clk);
      cycles++;
    end
    ar_seen = ar_total - ar_start;
    aw_seen = aw_total - aw_start;
    // request dropped for a cycle before the next one
    cpu_req.ren = 1'b0;
    cpu_req.wen = 1'b0;

    assert (write_ready == t.is_write && read_valid == !t.is_write) else begin
      $display("test %0d answered with the wrong kind of response", num);
      ok = 1'b0;
    end
    if (t.n_read == 0 && t.n_write == 0) begin
      // hits and direct stores answer one cycle after the request
      assert (cycles == 1) else begin
        $display("test %0d answered after %0d cycles instead of 1", num, cycles);
        ok = 1'b0;
      end
    end
    if (!t.is_write) begin
      assert (read_data === t.rdata) else begin
        $display("CHECK FAILED test %0d read_data got %h expected %h",
                 num, read_data, t.rdata);
        ok = 1'b0;
      end
    end
    assert (ar_seen == t.n_read) else begin
      $display("CHECK FAILED test %0d ar_count got %h expected %h", num, ar_seen, t.n_read);
      ok = 1'b0;
    end
    assert (aw_seen == t.n_write) else begin
      $display("CHECK FAILED test %0d aw_count got %h expected %h", num, aw_seen, t.n_write);
      ok = 1'b0;
    end

    $display("test %0d %s %h: %s", num, t.is_write ? "store" : "load", t.addr,
             ok ? "ok" : "FAILED");
    if (ok) begin
      pass_count++;
    end else begin
      fail_count++;
    end
  endtask

  initial begin
    cpu_req = '0;
    reset   = 1'b1;
    load_tests();
    tests_loaded = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    foreach (tests[i]) begin
      run_test(i, tests[i]);
    end
    $display("passed %0d, failed %0d of %0d", pass_count, fail_count, tests.size());
    if (fail_count == 0 && pass_count > 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (tests_loaded);
    repeat (RESET_CYCLES + tests.size() * CYCLES_PER_TEST) @(posedge clk);
    $display("timeout: no response within %0d cycles per test", CYCLES_PER_TEST);
    $display("test failed");
    $finish;
  end

endmodule

// ==== list.f ====
verilog/cache_pkg.sv
verilog/direct_map.sv
verilog/axi_lite_master.sv
verilog/d_cache.sv
verilog/data_memory_subsystem.sv
bench/axi_lite_mem_model.sv
bench/tb_data_memory.sv

// ==== bench/dcache_tests.txt ====
# columns in hex: op addr wdata strb rdata reads writes
# op 0 is a load and 1 a store, rdata is checked for loads only
0 80000010 00000000 f DA5A0010 1 0
0 80000010 00000000 f DA5A0010 0 0
1 80000011 000000AB 2 00000000 0 0
1 80000012 0000BEEF c 00000000 0 0
0 80000010 00000000 f BEEFAB10 0 0
0 80000013 00000000 8 BEEFABBE 0 0
1 80000020 12345678 f 00000000 0 0
0 80000020 00000000 f 12345678 0 0
0 80000410 00000000 f DA5A0410 1 1
1 80000420 CAFEF00D f 00000000 0 1
0 80000020 00000000 f 12345678 1 1
0 80000010 00000000 f BEEFAB10 1 0
0 80000420 00000000 f CAFEF00D 1 0
1 80000031 00000077 2 00000000 1 0
0 80000030 00000000 f DA5A7730 0 0
1 80000432 00000055 4 00000000 1 1
0 80000430 00000000 f DA550430 0 0
0 80000030 00000000 f DA5A7730 1 1
0 10000040 00000000 f 4A5A0040 1 0
0 10000040 00000000 f 4A5A0040 1 0
1 10000040 0BADF00D f 00000000 0 1
1 10000042 00001234 c 00000000 0 1
0 10000040 00000000 f 1234F00D 1 0
0 80010000 00000000 f DA5B0000 1 0
0 80010000 00000000 f DA5B0000 1 0
